/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    localparam int INT_BITS = 13;
    typedef logic [INT_BITS-1:0] int_vec_t;

    typedef struct packed {
        logic     we;
        csr_num_t num;
        word_t    wmask;
        word_t    wvalue;
    } csr_write_t;

    typedef struct packed {
        logic      ex;
        logic      ertn;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     vaddr;
        word_t     pc;
    } trap_event_t;

    // architectural CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // field positions
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE_BIT        = 2;
    localparam int CRMD_DA_BIT        = 3;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE_BIT       = 2;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TICLR_CLR_BIT      = 0;

    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // bit 10 reserved in ECFG.LIE
    localparam int_vec_t LIE_WRITABLE  = 13'h1bff;
    localparam int       TIMER_INT_BIT = 11;

    function automatic word_t csr_merge(word_t old_value, word_t mask, word_t value);
        return (mask & value) | (~mask & old_value);
    endfunction

endpackage

`default_nettype wire

/* rtl/csr_trap_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_trap_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_wr,
    input  csr_pkg::csr_write_t  csr_rd,
    input  csr_pkg::trap_event_t trap,
    output logic                 crmd_ie,
    output csr_pkg::word_t       ex_entry,
    output csr_pkg::word_t       ertn_entry,
    output csr_pkg::word_t       rdata
);
    import csr_pkg::*;

    plv_t                    crmd_plv;
    plv_t                    prmd_pplv;
    logic                    prmd_pie;
    word_t                   era;
    logic [31:EENTRY_VA_LSB] eentry_va;
    ecode_t                  estat_ecode;
    esubcode_t               estat_esubcode;
    word_t                   badv;

    word_t crmd_data;
    word_t prmd_data;
    word_t estat_data;
    word_t eentry_data;
    word_t crmd_next;
    word_t prmd_next;
    word_t era_next;
    word_t eentry_next;
    logic  addr_err;

    // DA reads as 1 with translation gone
    always_comb begin
        crmd_data = '0;
        crmd_data[CRMD_PLV_LSB +: 2] = crmd_plv;
        crmd_data[CRMD_IE_BIT] = crmd_ie;
        crmd_data[CRMD_DA_BIT] = 1'b1;
        prmd_data = '0;
        prmd_data[PRMD_PPLV_LSB +: 2] = prmd_pplv;
        prmd_data[PRMD_PIE_BIT] = prmd_pie;
        estat_data = '0;
        estat_data[ESTAT_ECODE_LSB +: 6] = estat_ecode;
        estat_data[ESTAT_ESUBCODE_LSB +: 9] = estat_esubcode;
        eentry_data = '0;
        eentry_data[31:EENTRY_VA_LSB] = eentry_va;
    end

    assign crmd_next   = csr_merge(crmd_data, csr_wr.wmask, csr_wr.wvalue);
    assign prmd_next   = csr_merge(prmd_data, csr_wr.wmask, csr_wr.wvalue);
    assign era_next    = csr_merge(era, csr_wr.wmask, csr_wr.wvalue);
    assign eentry_next = csr_merge(eentry_data, csr_wr.wmask, csr_wr.wvalue);

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_wr.we && csr_wr.num == CSR_CRMD) begin
            crmd_plv <= crmd_next[CRMD_PLV_LSB +: 2];
            crmd_ie  <= crmd_next[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            era            <= trap.pc;
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
        end else begin
            if (csr_wr.we && csr_wr.num == CSR_PRMD) begin
                prmd_pplv <= prmd_next[PRMD_PPLV_LSB +: 2];
                prmd_pie  <= prmd_next[PRMD_PIE_BIT];
            end
            if (csr_wr.we && csr_wr.num == CSR_ERA) begin
                era <= era_next;
            end
        end
        if (csr_wr.we && csr_wr.num == CSR_EENTRY) begin
            eentry_va <= eentry_next[31:EENTRY_VA_LSB];
        end
        // fetch faults report the pc itself
        if (trap.ex && addr_err) begin
            if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                badv <= trap.pc;
            end else begin
                badv <= trap.vaddr;
            end
        end
    end

    assign ex_entry   = eentry_data;
    assign ertn_entry = era;

    always_comb begin
        case (csr_rd.num)
            CSR_CRMD:   rdata = crmd_data;
            CSR_PRMD:   rdata = prmd_data;
            CSR_ESTAT:  rdata = estat_data;
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry_data;
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/csr_interrupt_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_interrupt_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t csr_wr,
    input  csr_pkg::csr_write_t csr_rd,
    input  logic                crmd_ie,
    input  logic                timer_int,
    output logic                has_int,
    output csr_pkg::word_t      rdata
);
    import csr_pkg::*;

    int_vec_t   lie;
    logic [1:0] swi;
    int_vec_t   is_vec;
    word_t      ecfg_next;
    word_t      estat_next;

    // hardware and inter-core lines read as zero
    always_comb begin
        is_vec = '0;
        is_vec[1:0] = swi;
        is_vec[TIMER_INT_BIT] = timer_int;
    end

    assign ecfg_next  = csr_merge(word_t'(lie), csr_wr.wmask, csr_wr.wvalue);
    assign estat_next = csr_merge(word_t'(is_vec), csr_wr.wmask, csr_wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
            swi <= '0;
        end else begin
            if (csr_wr.we && csr_wr.num == CSR_ECFG) begin
                lie <= ecfg_next[INT_BITS-1:0] & LIE_WRITABLE;
            end
            // only the software bits of ESTAT are writable
            if (csr_wr.we && csr_wr.num == CSR_ESTAT) begin
                swi <= estat_next[1:0];
            end
        end
    end

    assign has_int = (|(is_vec[TIMER_INT_BIT:0] & lie[TIMER_INT_BIT:0])) & crmd_ie;

    always_comb begin
        case (csr_rd.num)
            CSR_ECFG:  rdata = word_t'(lie);
            CSR_ESTAT: rdata = word_t'(is_vec);
            default:   rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/csr_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_timer #(
    parameter int TIMER_BITS = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t csr_wr,
    input  csr_pkg::csr_write_t csr_rd,
    output logic                timer_int,
    output csr_pkg::word_t      rdata
);
    import csr_pkg::*;

    word_t                 tid;
    logic                  tcfg_en;
    logic                  tcfg_periodic;
    logic [TIMER_BITS-3:0] tcfg_initval;
    logic [TIMER_BITS-1:0] timer_cnt;

    logic [TIMER_BITS-1:0] tcfg_q;
    logic [TIMER_BITS-1:0] tcfg_next;
    word_t                 tcfg_merged;
    word_t                 tid_next;
    logic                  wr_tcfg;
    logic                  ticlr;

    assign tcfg_q      = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_merged = csr_merge(word_t'(tcfg_q), csr_wr.wmask, csr_wr.wvalue);
    assign tcfg_next   = tcfg_merged[TIMER_BITS-1:0];
    assign tid_next    = csr_merge(tid, csr_wr.wmask, csr_wr.wvalue);

    assign wr_tcfg = csr_wr.we && csr_wr.num == CSR_TCFG;
    assign ticlr   = csr_wr.we && csr_wr.num == CSR_TICLR
                     && csr_wr.wmask[TICLR_CLR_BIT] && csr_wr.wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid     <= '0;
            tcfg_en <= 1'b0;
        end else begin
            if (csr_wr.we && csr_wr.num == CSR_TID) begin
                tid <= tid_next;
            end
            if (wr_tcfg) begin
                tcfg_en <= tcfg_next[TCFG_EN_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[TIMER_BITS-1:TCFG_INITVAL_LSB];
        end
    end

    // all ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (wr_tcfg && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[TIMER_BITS-1:TCFG_INITVAL_LSB], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // set beats clear
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (csr_rd.num)
            CSR_TID:  rdata = tid;
            CSR_TCFG: rdata = word_t'(tcfg_q);
            CSR_TVAL: rdata = word_t'(timer_cnt);
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/csr_scratch_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_scratch_regs (
    input  logic                clk,
    input  csr_pkg::csr_write_t csr_wr,
    input  csr_pkg::csr_write_t csr_rd,
    output csr_pkg::word_t      rdata
);
    import csr_pkg::*;

    localparam int NUM_SAVE = 4;

    word_t save_q [NUM_SAVE];

    // SAVE0..SAVE3 are consecutive numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_wr.we && csr_wr.num == csr_num_t'(CSR_SAVE0 + i)) begin
                save_q[i] <= csr_merge(save_q[i], csr_wr.wmask, csr_wr.wvalue);
            end
        end
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_rd.num == csr_num_t'(CSR_SAVE0 + i)) begin
                rdata = save_q[i];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file #(
    parameter int TIMER_BITS = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_wr,
    input  csr_pkg::trap_event_t trap,
    input  csr_pkg::csr_num_t    rd_num,
    output csr_pkg::word_t       csr_rvalue,
    output csr_pkg::word_t       ex_entry,
    output csr_pkg::word_t       ertn_entry,
    output logic                 has_int
);
    import csr_pkg::*;

    csr_write_t csr_rd;
    logic       crmd_ie;
    logic       timer_int;
    word_t      trap_rdata;
    word_t      int_rdata;
    word_t      timer_rdata;
    word_t      scratch_rdata;

    // read decode runs off rd_num
    always_comb begin
        csr_rd = csr_wr;
        csr_rd.num = rd_num;
    end

    csr_trap_regs u_trap_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .csr_rd     (csr_rd),
        .trap       (trap),
        .crmd_ie    (crmd_ie),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .rdata      (trap_rdata)
    );

    csr_interrupt_ctrl u_interrupt_ctrl (
        .clk       (clk),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .csr_rd    (csr_rd),
        .crmd_ie   (crmd_ie),
        .timer_int (timer_int),
        .has_int   (has_int),
        .rdata     (int_rdata)
    );

    csr_timer #(
        .TIMER_BITS (TIMER_BITS)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .csr_rd    (csr_rd),
        .timer_int (timer_int),
        .rdata     (timer_rdata)
    );

    csr_scratch_regs u_scratch_regs (
        .clk    (clk),
        .csr_wr (csr_wr),
        .csr_rd (csr_rd),
        .rdata  (scratch_rdata)
    );

    // each group drives zero when the number is not its own
    assign csr_rvalue = trap_rdata | int_rdata | timer_rdata | scratch_rdata;

endmodule

`default_nettype wire

/* verif/csr_file_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file_properties (
    input logic              clk,
    input logic              reset,
    input logic              crmd_ie,
    input logic              has_int,
    input csr_pkg::csr_num_t rd_num,
    input csr_pkg::word_t    csr_rvalue,
    input csr_pkg::word_t    ex_entry
);
    import csr_pkg::*;

    int violations = 0;

    no_int_when_masked: assert property (
        @(posedge clk) disable iff (reset) !crmd_ie |-> !has_int
    ) else begin
        violations = violations + 1;
        $error("has_int is high while CRMD.IE is clear");
    end

    // reserved LIE bit seen through the read port
    ecfg_bit10_clear: assert property (
        @(posedge clk) disable iff (reset) (rd_num == CSR_ECFG) |-> !csr_rvalue[10]
    ) else begin
        violations = violations + 1;
        $error("ECFG bit 10 reads as set");
    end

    entry_aligned: assert property (
        @(posedge clk) disable iff (reset) ex_entry[5:0] == 6'd0
    ) else begin
        violations = violations + 1;
        $error("ex_entry has nonzero low bits");
    end

endmodule

bind csr_file csr_file_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .crmd_ie    (crmd_ie),
    .has_int    (has_int),
    .rd_num     (rd_num),
    .csr_rvalue (csr_rvalue),
    .ex_entry   (ex_entry)
);

`default_nettype wire

/* verif/csr_file_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file_checker #(
    parameter int NUM_TESTS = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_wr,
    input  csr_pkg::trap_event_t trap,
    input  csr_pkg::csr_num_t    rd_num,
    input  csr_pkg::word_t       csr_rvalue,
    input  csr_pkg::word_t       ex_entry,
    input  csr_pkg::word_t       ertn_entry,
    input  logic                 has_int,
    input  int                   test_id,
    output int                   checks,
    output int                   errors,
    output int                   tests_failed
);
    import csr_pkg::*;

    // reference state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    word_t       m_era;
    word_t       m_eentry;
    word_t       m_badv;
    ecode_t      m_ecode;
    esubcode_t   m_esub;
    logic [12:0] m_lie;
    logic [1:0]  m_swi;
    word_t       m_tid;
    logic        m_en;
    logic        m_per;
    logic [29:0] m_init;
    word_t       m_cnt;
    logic        m_tint;
    word_t       m_save [4];

    word_t wm;
    int    cur_id = 0;
    int    test_checks = 0;
    int    test_errors = 0;

    initial begin
        checks = 0;
        errors = 0;
        tests_failed = 0;
    end

    function automatic string test_name(int id);
        case (id)
            1:       return "random_masked_writes";
            2:       return "exception_entry";
            3:       return "exception_return";
            4:       return "oneshot_timer";
            5:       return "timer_and_soft_int";
            default: return "unknown";
        endcase
    endfunction

    function automatic word_t merge_bits(word_t old_value, word_t mask, word_t value);
        return (old_value & ~mask) | (value & mask);
    endfunction

    function automatic word_t expected_read(csr_num_t num);
        word_t v;
        v = '0;
        case (num)
            CSR_CRMD:   v = {28'd0, 1'b1, m_ie, m_plv};
            CSR_PRMD:   v = {29'd0, m_pie, m_pplv};
            CSR_ECFG:   v = {19'd0, m_lie};
            CSR_ESTAT:  v = {1'b0, m_esub, m_ecode, 4'd0, m_tint, 9'd0, m_swi};
            CSR_ERA:    v = m_era;
            CSR_BADV:   v = m_badv;
            CSR_EENTRY: v = m_eentry;
            CSR_SAVE0:  v = m_save[0];
            CSR_SAVE1:  v = m_save[1];
            CSR_SAVE2:  v = m_save[2];
            CSR_SAVE3:  v = m_save[3];
            CSR_TID:    v = m_tid;
            CSR_TCFG:   v = {m_init, m_per, m_en};
            CSR_TVAL:   v = m_cnt;
            default:    v = '0;
        endcase
        return v;
    endfunction

    function automatic logic expected_has_int();
        logic [11:0] pending;
        pending = {m_tint, 9'd0, m_swi};
        return m_ie && (|(pending & m_lie[11:0]));
    endfunction

    always @(posedge clk) begin
        wm = merge_bits(expected_read(csr_wr.num), csr_wr.wmask, csr_wr.wvalue);
        if (reset) begin
            m_plv  <= '0;
            m_ie   <= 1'b0;
            m_lie  <= '0;
            m_swi  <= '0;
            m_tid  <= '0;
            m_en   <= 1'b0;
            m_cnt  <= '1;
            m_tint <= 1'b0;
        end else begin
            if (trap.ex) begin
                m_plv   <= '0;
                m_ie    <= 1'b0;
                m_pplv  <= m_plv;
                m_pie   <= m_ie;
                m_era   <= trap.pc;
                m_ecode <= trap.ecode;
                m_esub  <= trap.esubcode;
                if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                    m_badv <= trap.pc;
                end else if (trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE) begin
                    m_badv <= trap.vaddr;
                end
            end else if (trap.ertn) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (csr_wr.we && csr_wr.num == CSR_CRMD) begin
                m_plv <= wm[1:0];
                m_ie  <= wm[2];
            end
            if (!trap.ex && csr_wr.we && csr_wr.num == CSR_PRMD) begin
                m_pplv <= wm[1:0];
                m_pie  <= wm[2];
            end
            if (!trap.ex && csr_wr.we && csr_wr.num == CSR_ERA) begin
                m_era <= wm;
            end
            if (csr_wr.we) begin
                case (csr_wr.num)
                    CSR_ECFG:   m_lie <= wm[12:0] & LIE_WRITABLE;
                    CSR_ESTAT:  m_swi <= wm[1:0];
                    CSR_EENTRY: m_eentry <= wm & 32'hffff_ffc0;
                    CSR_TID:    m_tid <= wm;
                    CSR_SAVE0:  m_save[0] <= wm;
                    CSR_SAVE1:  m_save[1] <= wm;
                    CSR_SAVE2:  m_save[2] <= wm;
                    CSR_SAVE3:  m_save[3] <= wm;
                    CSR_TCFG: begin
                        m_en   <= wm[0];
                        m_per  <= wm[1];
                        m_init <= wm[31:2];
                    end
                    default: ;
                endcase
            end
            // countdown stops at all ones
            if (csr_wr.we && csr_wr.num == CSR_TCFG && wm[0]) begin
                m_cnt <= {wm[31:2], 2'b00};
            end else if (m_en && m_cnt != 32'hffff_ffff) begin
                m_cnt <= (m_cnt == 32'd0 && m_per) ? {m_init, 2'b00} : m_cnt - 32'd1;
            end
            if (m_cnt == 32'd0) begin
                m_tint <= 1'b1;
            end else if (csr_wr.we && csr_wr.num == CSR_TICLR
                         && csr_wr.wmask[0] && csr_wr.wvalue[0]) begin
                m_tint <= 1'b0;
            end
        end
    end

    task automatic check_value(input string what, input word_t exp, input word_t act);
        checks = checks + 1;
        test_checks = test_checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("Fail %s: %s expected %h actual %h", test_name(cur_id), what, exp, act);
        end
    endtask

    // compare mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (test_id != cur_id) begin
            if (cur_id > 0 && cur_id < NUM_TESTS) begin
                if (test_errors == 0) begin
                    $display("test %s: passed, %0d checks", test_name(cur_id), test_checks);
                end else begin
                    tests_failed = tests_failed + 1;
                    $display("test %s: failed, %0d of %0d checks wrong",
                             test_name(cur_id), test_errors, test_checks);
                end
            end
            cur_id = test_id;
            test_checks = 0;
            test_errors = 0;
        end
        if (!reset && cur_id > 0 && cur_id < NUM_TESTS) begin
            check_value($sformatf("csr_rvalue[%03h]", rd_num), expected_read(rd_num), csr_rvalue);
            check_value("ex_entry", m_eentry, ex_entry);
            check_value("ertn_entry", m_era, ertn_entry);
            check_value("has_int", word_t'(expected_has_int()), word_t'(has_int));
        end
    end

endmodule

`default_nettype wire

/* verif/csr_file_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 6;
    localparam int N_RAND      = 32;
    localparam int TIMER_N     = 5;
    localparam int TEST_CYCLES = 2 * N_RAND + 4 * TIMER_N + 100;
    localparam int MARGIN      = 50;

    logic        clk;
    logic        reset;
    csr_write_t  csr_wr;
    trap_event_t trap;
    csr_num_t    rd_num;
    word_t       csr_rvalue;
    word_t       ex_entry;
    word_t       ertn_entry;
    logic        has_int;

    int       test_id;
    int       cur_test;
    integer   seed;
    int       tb_errors;
    int       checks;
    int       errors;
    int       tests_failed;
    int       other_errors;
    word_t    rnd_pick;
    word_t    rnd_mask;
    word_t    rnd_value;
    csr_num_t target;

    csr_file #(
        .TIMER_BITS (32)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .trap       (trap),
        .rd_num     (rd_num),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int)
    );

    csr_file_checker #(
        .NUM_TESTS (NUM_TESTS)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .csr_wr       (csr_wr),
        .trap         (trap),
        .rd_num       (rd_num),
        .csr_rvalue   (csr_rvalue),
        .ex_entry     (ex_entry),
        .ertn_entry   (ertn_entry),
        .has_int      (has_int),
        .test_id      (test_id),
        .checks       (checks),
        .errors       (errors),
        .tests_failed (tests_failed)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_write_t make_write(csr_num_t num, word_t mask, word_t value);
        csr_write_t w;
        w.we = 1'b1;
        w.num = num;
        w.wmask = mask;
        w.wvalue = value;
        return w;
    endfunction

    function automatic trap_event_t make_trap(logic ex, logic ertn, ecode_t ecode,
                                              esubcode_t esub, word_t vaddr, word_t pc);
        trap_event_t t;
        t.ex = ex;
        t.ertn = ertn;
        t.ecode = ecode;
        t.esubcode = esub;
        t.vaddr = vaddr;
        t.pc = pc;
        return t;
    endfunction

    function automatic csr_num_t random_target(int k);
        case (k)
            0:       return CSR_SAVE0;
            1:       return CSR_SAVE1;
            2:       return CSR_SAVE2;
            3:       return CSR_SAVE3;
            4:       return CSR_ERA;
            5:       return CSR_EENTRY;
            6:       return CSR_ECFG;
            7:       return CSR_PRMD;
            default: return CSR_TID;
        endcase
    endfunction

    // one cycle of stimulus at the rising edge
    task automatic drive(input csr_write_t wr, input trap_event_t tr, input csr_num_t num);
        @(posedge clk);
        csr_wr  <= wr;
        trap    <= tr;
        rd_num  <= num;
        test_id <= cur_test;
    endtask

    task automatic write_csr(input csr_num_t num, input word_t mask, input word_t value);
        drive(make_write(num, mask, value), '0, num);
    endtask

    task automatic read_csr(input csr_num_t num);
        drive('0, '0, num);
    endtask

    task automatic raise_trap(input logic ex, input logic ertn, input ecode_t ecode,
                              input esubcode_t esub, input word_t vaddr, input word_t pc);
        drive('0, make_trap(ex, ertn, ecode, esub, vaddr, pc), CSR_CRMD);
    endtask

    task automatic wait_for_has_int(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!has_int && n < limit) begin
            read_csr(CSR_ESTAT);
            @(negedge clk);
            n = n + 1;
        end
        if (!has_int) begin
            tb_errors = tb_errors + 1;
            $display("has_int did not rise for %s within %0d cycles", what, limit);
        end
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        csr_wr = '0;
        trap = '0;
        rd_num = '0;
        test_id = 0;
        cur_test = 0;
        tb_errors = 0;
        seed = 32'h0dce_e39b;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // bring every register without reset to a known value
        write_csr(CSR_SAVE0, '1, 32'h0);
        write_csr(CSR_SAVE1, '1, 32'h0);
        write_csr(CSR_SAVE2, '1, 32'h0);
        write_csr(CSR_SAVE3, '1, 32'h0);
        write_csr(CSR_EENTRY, '1, 32'h0);
        write_csr(CSR_TCFG, '1, 32'h0);
        raise_trap(1'b1, 1'b0, ECODE_ALE, 9'h0, 32'h0, 32'h0);

        cur_test = 1;
        for (int i = 0; i < N_RAND; i++) begin
            rnd_pick = $random(seed);
            rnd_mask = $random(seed);
            rnd_value = $random(seed);
            target = random_target(int'(rnd_pick % 9));
            write_csr(target, rnd_mask, rnd_value);
            read_csr(target);
        end

        cur_test = 2;
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        write_csr(CSR_EENTRY, '1, 32'h1c00_807f);
        raise_trap(1'b1, 1'b0, ECODE_ALE, 9'h0, 32'h0000_1236, 32'h1c00_0100);
        read_csr(CSR_CRMD);
        read_csr(CSR_PRMD);
        read_csr(CSR_ERA);
        read_csr(CSR_ESTAT);
        read_csr(CSR_BADV);
        write_csr(CSR_CRMD, 32'h7, 32'h5);
        raise_trap(1'b1, 1'b0, ECODE_ADE, ESUBCODE_ADEF, 32'hdead_beef, 32'h1c00_0203);
        read_csr(CSR_BADV);
        read_csr(CSR_ESTAT);
        read_csr(CSR_PRMD);
        // syscall leaves BADV alone
        raise_trap(1'b1, 1'b0, 6'h0b, 9'h0, 32'h1234_5678, 32'h1c00_0300);
        read_csr(CSR_BADV);

        cur_test = 3;
        write_csr(CSR_PRMD, 32'h7, 32'h6);
        raise_trap(1'b0, 1'b1, 6'h0, 9'h0, 32'h0, 32'h0);
        read_csr(CSR_CRMD);
        write_csr(CSR_PRMD, 32'h7, 32'h1);
        write_csr(CSR_ERA, '1, 32'h1c00_0400);
        raise_trap(1'b0, 1'b1, 6'h0, 9'h0, 32'h0, 32'h0);
        read_csr(CSR_CRMD);
        raise_trap(1'b1, 1'b1, 6'h0c, 9'h0, 32'h0, 32'h1c00_0500);
        read_csr(CSR_CRMD);
        read_csr(CSR_PRMD);
        read_csr(CSR_ERA);

        cur_test = 4;
        write_csr(CSR_TCFG, '1, (TIMER_N << 2) | 1);
        repeat (4 * TIMER_N + 4) read_csr(CSR_TVAL);
        read_csr(CSR_ESTAT);
        read_csr(CSR_ESTAT);
        read_csr(CSR_TCFG);

        cur_test = 5;
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_ECFG, '1, 32'h800);
        write_csr(CSR_TCFG, '1, (2 << 2) | 1);
        wait_for_has_int(4 * 2 + 6, "the timer interrupt");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        write_csr(CSR_ECFG, '1, 32'h801);
        write_csr(CSR_ESTAT, 32'h3, 32'h1);
        wait_for_has_int(4, "the software interrupt");
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        read_csr(CSR_ESTAT);

        cur_test = NUM_TESTS;
        read_csr(CSR_CRMD);
        read_csr(CSR_CRMD);
        @(negedge clk);
        other_errors = tb_errors + DUT.u_props.violations;
        $display("%0d tests, %0d failed, %0d checks, %0d value errors, %0d other errors",
                 NUM_TESTS - 1, tests_failed, checks, errors, other_errors);
        if (errors == 0 && tests_failed == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_file.f */
rtl/csr_pkg.sv
rtl/csr_trap_regs.sv
rtl/csr_interrupt_ctrl.sv
rtl/csr_timer.sv
rtl/csr_scratch_regs.sv
rtl/csr_file.sv
verif/csr_file_properties.sv
verif/csr_file_checker.sv
verif/csr_file_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module csr_file_tb -f csr_file.f -o sim_csr_file

./obj_dir/sim_csr_file +verilator+error+limit+1000 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
